// ==== periph_pkg.sv ====
// Peripheral bus definitions
`default_nettype none

package periph_pkg;

  // Host bus widths.
  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;

  // Register offset seen by each device.
  localparam int unsigned RegAddrWidth = 8;

  ////////////////////
  // Devices.
  ////////////////////

  typedef enum int {
    Gpio,
    Pwm,
    Timer
  } bus_device_e;

  localparam int NrDevices = 3;

  ////////////////////
  // Address map.
  ////////////////////

  // Each device owns one 4 KiB window.
  localparam logic [BusAddrWidth-1:0] GpioBase  = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] PwmBase   = 32'h8000_1000;
  localparam logic [BusAddrWidth-1:0] TimerBase = 32'h8000_2000;

  // Keeps only the window select bits.
  localparam logic [BusAddrWidth-1:0] DevAddrMask = 32'hFFFF_F000;

endpackage

`default_nettype wire

// ==== periph_bus_decode.sv ====
// Peripheral address decoder
`default_nettype none
`timescale 1ns/1ns

module periph_bus_decode (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,

  // Host port.
  input  logic                                 host_req_i,
  input  logic                                 host_we_i,
  input  logic [periph_pkg::BusAddrWidth-1:0]  host_addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] host_be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  host_wdata_i,
  output logic                                 host_rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  host_rdata_o,
  output logic                                 host_err_o,

  // Device ports, indexed by device.
  output logic                                 dev_req_o    [periph_pkg::NrDevices],
  output logic                                 dev_we_o     [periph_pkg::NrDevices],
  output logic [periph_pkg::RegAddrWidth-1:0]  dev_addr_o   [periph_pkg::NrDevices],
  output logic [periph_pkg::BusByteEnable-1:0] dev_be_o     [periph_pkg::NrDevices],
  output logic [periph_pkg::BusDataWidth-1:0]  dev_wdata_o  [periph_pkg::NrDevices],
  input  logic                                 dev_rvalid_i [periph_pkg::NrDevices],
  input  logic [periph_pkg::BusDataWidth-1:0]  dev_rdata_i  [periph_pkg::NrDevices],
  input  logic                                 dev_err_i    [periph_pkg::NrDevices]
);
  import periph_pkg::*;

  logic [NrDevices-1:0]    dev_sel;
  logic [NrDevices-1:0]    dev_req;
  logic                    unmapped;
  logic [NrDevices-1:0]    sel_q;
  logic                    unmapped_q;
  logic [NrDevices-1:0]    rvalid_vec;
  logic [NrDevices-1:0]    err_vec;
  logic [BusDataWidth-1:0] rdata_mux;

  ////////////////////
  // Request path.
  ////////////////////

  // Match the window bits against each base.
  always_comb begin
    dev_sel        = '0;
    dev_sel[Gpio]  = (host_addr_i & DevAddrMask) == GpioBase;
    dev_sel[Pwm]   = (host_addr_i & DevAddrMask) == PwmBase;
    dev_sel[Timer] = (host_addr_i & DevAddrMask) == TimerBase;
  end

  assign unmapped = ~|dev_sel;
  assign dev_req  = dev_sel & {NrDevices{host_req_i}};

  for (genvar i = 0; i < NrDevices; i++) begin : gen_dev
    assign dev_req_o[i]   = dev_req[i];
    assign dev_we_o[i]    = dev_req[i] & host_we_i;
    assign dev_addr_o[i]  = host_addr_i[RegAddrWidth-1:0];
    assign dev_be_o[i]    = host_be_i;
    assign dev_wdata_o[i] = host_wdata_i;
    // Only the device selected last cycle may answer.
    assign rvalid_vec[i]  = dev_rvalid_i[i] & sel_q[i];
    assign err_vec[i]     = dev_err_i[i] & sel_q[i];
  end

  ////////////////////
  // Response path.
  ////////////////////

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q      <= '0;
      unmapped_q <= 1'b0;
    end else begin
      sel_q      <= dev_req;
      unmapped_q <= host_req_i & unmapped;
    end
  end

  always_comb begin
    rdata_mux = '0;
    for (int i = 0; i < NrDevices; i++) begin
      if (sel_q[i]) begin
        rdata_mux = rdata_mux | dev_rdata_i[i];
      end
    end
  end

  // Unmapped access: valid, error, data stays zero.
  assign host_rvalid_o = unmapped_q | (|rvalid_vec);
  assign host_rdata_o  = rdata_mux;
  assign host_err_o    = unmapped_q | (|err_vec);

  // No two devices are strobed together.
  assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    $onehot0(dev_req));

  // Every response belongs to a request one cycle earlier.
  assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    host_rvalid_o |-> $past(host_req_i));

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
// General purpose I/O registers
`default_nettype none
`timescale 1ns/1ns

module gpio_regs #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,

  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [periph_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  wdata_i,
  output logic                                 rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  rdata_o,

  input  logic [GpiWidth-1:0]                  gp_i,
  output logic [GpoWidth-1:0]                  gp_o
);
  import periph_pkg::*;

  localparam logic [RegAddrWidth-1:0] GpoOffset = 8'h00;
  localparam logic [RegAddrWidth-1:0] GpiOffset = 8'h04;

  logic [GpoWidth-1:0]     gpo_q;
  logic [GpiWidth-1:0]     gpi_meta_q;
  logic [GpiWidth-1:0]     gpi_sync_q;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  // Output register, one byte lane per enable.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpo_q <= '0;
    end else if (req_i && we_i && addr_i == GpoOffset) begin
      for (int i = 0; i < GpoWidth; i++) begin
        if (be_i[i/8]) begin
          gpo_q[i] <= wdata_i[i];
        end
      end
    end
  end

  // Two-flop synchronizer on the inputs.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Read data; writes answer with zero.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= '0;
      if (!we_i && addr_i == GpoOffset) begin
        rdata_q[GpoWidth-1:0] <= gpo_q;
      end else if (!we_i && addr_i == GpiOffset) begin
        rdata_q[GpiWidth-1:0] <= gpi_sync_q;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign gp_o     = gpo_q;

endmodule

`default_nettype wire

// ==== pwm_bank.sv ====
// PWM channel bank
`default_nettype none
`timescale 1ns/1ns

module pwm_bank #(
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,

  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [periph_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  wdata_i,
  output logic                                 rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  rdata_o,

  output logic [PwmWidth-1:0]                  pwm_o
);
  import periph_pkg::*;

  // Field positions inside a channel word.
  localparam int unsigned DutyLsb   = 0;
  localparam int unsigned PeriodLsb = 8;

  logic [PwmWidth-1:0]     ch_hit;
  logic [PwmCtrSize-1:0]   duty_q     [PwmWidth];
  logic [PwmCtrSize-1:0]   period_q   [PwmWidth];
  logic [BusDataWidth-1:0] rd_word;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_ch
    logic [PwmCtrSize-1:0] ctr_q;
    logic [PwmCtrSize-1:0] duty_act_q;
    logic [PwmCtrSize-1:0] period_act_q;

    assign ch_hit[i] = addr_i == RegAddrWidth'(4 * i);

    // Programmed values.
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        duty_q[i]   <= '0;
        period_q[i] <= '0;
      end else if (req_i && we_i && ch_hit[i]) begin
        if (be_i[0]) begin
          duty_q[i] <= wdata_i[DutyLsb +: PwmCtrSize];
        end
        if (be_i[1]) begin
          period_q[i] <= wdata_i[PeriodLsb +: PwmCtrSize];
        end
      end
    end

    // Counter; new settings are picked up on wrap.
    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        ctr_q        <= '0;
        duty_act_q   <= '0;
        period_act_q <= '0;
      end else if (ctr_q >= period_act_q) begin
        ctr_q        <= '0;
        duty_act_q   <= duty_q[i];
        period_act_q <= period_q[i];
      end else begin
        ctr_q <= ctr_q + 1'b1;
      end
    end

    assign pwm_o[i] = ctr_q < duty_act_q;

    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
      ctr_q <= period_act_q);
  end

  // Read back the addressed channel.
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < PwmWidth; i++) begin
      if (ch_hit[i]) begin
        rd_word[DutyLsb +: PwmCtrSize]   = duty_q[i];
        rd_word[PeriodLsb +: PwmCtrSize] = period_q[i];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : rd_word;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== mtimer.sv ====
// Machine timer
`default_nettype none
`timescale 1ns/1ns

module mtimer (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,

  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [periph_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  wdata_i,
  output logic                                 rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  rdata_o,
  output logic                                 err_o,

  output logic                                 timer_irq_o
);
  import periph_pkg::*;

  localparam logic [RegAddrWidth-1:0] MtimeLo = 8'h00;
  localparam logic [RegAddrWidth-1:0] MtimeHi = 8'h04;
  localparam logic [RegAddrWidth-1:0] CmpLo   = 8'h08;
  localparam logic [RegAddrWidth-1:0] CmpHi   = 8'h0C;

  logic [63:0]             mtime_q;
  logic [63:0]             mtimecmp_q;
  logic                    expired;
  logic                    irq_q;
  logic                    hit;
  logic [BusDataWidth-1:0] rd_word;
  logic                    rvalid_q;
  logic                    err_q;
  logic [BusDataWidth-1:0] rdata_q;

  ////////////////////
  // Time and compare.
  ////////////////////

  // Free running, one tick per clock.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // Compare register, written per byte lane.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtimecmp_q <= '1;
    end else if (req_i && we_i) begin
      for (int b = 0; b < BusByteEnable; b++) begin
        if (be_i[b] && addr_i == CmpLo) begin
          mtimecmp_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
        if (be_i[b] && addr_i == CmpHi) begin
          mtimecmp_q[BusDataWidth + b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign expired = mtime_q >= mtimecmp_q;

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= expired;
    end
  end

  ////////////////////
  // Register access.
  ////////////////////

  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    unique case (addr_i)
      MtimeLo: rd_word = mtime_q[31:0];
      MtimeHi: rd_word = mtime_q[63:32];
      CmpLo:   rd_word = mtimecmp_q[31:0];
      CmpHi:   rd_word = mtimecmp_q[63:32];
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & ~hit;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : rd_word;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign timer_irq_o = irq_q;

  // Interrupt tracks last cycle's compare.
  assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
    timer_irq_o == $past(mtime_q >= mtimecmp_q));

endmodule

`default_nettype wire

// ==== sonata_periph_top.sv ====
// Sonata peripheral subsystem
`default_nettype none
`timescale 1ns/1ns

module sonata_periph_top #(
  parameter int unsigned GpiWidth   = 13,
  parameter int unsigned GpoWidth   = 24,
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                                 clk_sys_i,
  input  logic                                 arst_n_i,

  // Host port.
  input  logic                                 host_req_i,
  input  logic                                 host_we_i,
  input  logic [periph_pkg::BusAddrWidth-1:0]  host_addr_i,
  input  logic [periph_pkg::BusByteEnable-1:0] host_be_i,
  input  logic [periph_pkg::BusDataWidth-1:0]  host_wdata_i,
  output logic                                 host_rvalid_o,
  output logic [periph_pkg::BusDataWidth-1:0]  host_rdata_o,
  output logic                                 host_err_o,

  input  logic [GpiWidth-1:0]                  gp_i,
  output logic [GpoWidth-1:0]                  gp_o,
  output logic [PwmWidth-1:0]                  pwm_o,
  output logic                                 timer_irq_o
);
  import periph_pkg::*;

  logic                     dev_req    [NrDevices];
  logic                     dev_we     [NrDevices];
  logic [RegAddrWidth-1:0]  dev_addr   [NrDevices];
  logic [BusByteEnable-1:0] dev_be     [NrDevices];
  logic [BusDataWidth-1:0]  dev_wdata  [NrDevices];
  logic                     dev_rvalid [NrDevices];
  logic [BusDataWidth-1:0]  dev_rdata  [NrDevices];
  logic                     dev_err    [NrDevices];

  // Only the timer reports bad offsets.
  assign dev_err[Gpio] = 1'b0;
  assign dev_err[Pwm]  = 1'b0;

  periph_bus_decode u_decode (
    .clk_sys_i    (clk_sys_i),
    .arst_n_i     (arst_n_i),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .dev_req_o    (dev_req),
    .dev_we_o     (dev_we),
    .dev_addr_o   (dev_addr),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .dev_rvalid_i (dev_rvalid),
    .dev_rdata_i  (dev_rdata),
    .dev_err_i    (dev_err)
  );

  ////////////////////
  // Devices.
  ////////////////////

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .req_i    (dev_req[Gpio]),
    .we_i     (dev_we[Gpio]),
    .addr_i   (dev_addr[Gpio]),
    .be_i     (dev_be[Gpio]),
    .wdata_i  (dev_wdata[Gpio]),
    .rvalid_o (dev_rvalid[Gpio]),
    .rdata_o  (dev_rdata[Gpio]),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm_bank #(
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize)
  ) u_pwm (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .req_i    (dev_req[Pwm]),
    .we_i     (dev_we[Pwm]),
    .addr_i   (dev_addr[Pwm]),
    .be_i     (dev_be[Pwm]),
    .wdata_i  (dev_wdata[Pwm]),
    .rvalid_o (dev_rvalid[Pwm]),
    .rdata_o  (dev_rdata[Pwm]),
    .pwm_o    (pwm_o)
  );

  mtimer u_timer (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .req_i      (dev_req[Timer]),
    .we_i       (dev_we[Timer]),
    .addr_i     (dev_addr[Timer]),
    .be_i       (dev_be[Timer]),
    .wdata_i    (dev_wdata[Timer]),
    .rvalid_o   (dev_rvalid[Timer]),
    .rdata_o    (dev_rdata[Timer]),
    .err_o      (dev_err[Timer]),
    .timer_irq_o(timer_irq_o)
  );

endmodule

`default_nettype wire

// ==== tb_sonata_periph.sv ====
// Peripheral subsystem testbench
`default_nettype none
`timescale 1ns/1ns

module tb_sonata_periph;

  // Address map and sizes as seen from the host.
  localparam logic [31:0] GpioAddr   = 32'h8000_0000;
  localparam logic [31:0] PwmAddr    = 32'h8000_1000;
  localparam logic [31:0] TimerAddr  = 32'h8000_2000;
  localparam int          GpiBits    = 13;
  localparam int          GpoBits    = 24;
  localparam int          PwmPeriod  = 9;
  localparam int          PwmDuty    = 4;
  localparam int          PwmDutyBig = 20;
  localparam int          IdleExtra  = 5;
  localparam int          IrqCycles  = 2;
  // Two measurements of three periods each.
  localparam int          PwmWindows = 2 * 3 * (PwmPeriod + 1);

  logic                clk_sys = 1'b0;
  logic                arst_n;
  logic                host_req;
  logic                host_we;
  logic [31:0]         host_addr;
  logic [3:0]          host_be;
  logic [31:0]         host_wdata;
  logic                host_rvalid_o;
  logic [31:0]         host_rdata_o;
  logic                host_err_o;
  logic [GpiBits-1:0]  gp_i;
  logic [GpoBits-1:0]  gp_o;
  logic [11:0]         pwm_o;
  logic                timer_irq;

  int                  seed;
  logic [31:0]         gp_val;
  logic [GpoBits-1:0]  gpo_model;
  int                  n_checks = 0;
  int                  n_errors = 0;
  int                  cycle_count = 0;
  int                  timeout_limit;

  // Stimulus table, one entry per bus access.
  string               tbl_name  [$];
  logic                tbl_we    [$];
  logic [31:0]         tbl_addr  [$];
  logic [3:0]          tbl_be    [$];
  logic [31:0]         tbl_wdata [$];
  logic [31:0]         tbl_rdata [$];
  logic                tbl_err   [$];

  sonata_periph_top #(
    .GpiWidth  (GpiBits),
    .GpoWidth  (GpoBits),
    .PwmWidth  (12),
    .PwmCtrSize(8)
  ) i_sonata_periph_top (
    .clk_sys_i    (clk_sys),
    .arst_n_i     (arst_n),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_be_i    (host_be),
    .host_wdata_i (host_wdata),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .pwm_o        (pwm_o),
    .timer_irq_o  (timer_irq)
  );

  always #20 clk_sys = ~clk_sys;

  ////////////////////
  // Helpers.
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic add_test(input string name, input logic we, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] wdata,
                          input logic [31:0] rdata, input logic err);
    tbl_name.push_back(name);
    tbl_we.push_back(we);
    tbl_addr.push_back(addr);
    tbl_be.push_back(be);
    tbl_wdata.push_back(wdata);
    tbl_rdata.push_back(rdata);
    tbl_err.push_back(err);
  endtask

  // One-cycle request; returns while the response is on the bus.
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
    @(posedge clk_sys);
    #2;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_be    = be;
    host_wdata = wdata;
    @(posedge clk_sys);
    #2;
    host_req = 1'b0;
    host_we  = 1'b0;
    @(negedge clk_sys);
  endtask

  task automatic bus_check(input string name, input logic we, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err);
    bus_access(we, addr, be, wdata);
    check_value({name, " rvalid"}, 32'd1, 32'(host_rvalid_o));
    check_value({name, " rdata"}, exp_rdata, host_rdata_o);
    check_value({name, " err"}, 32'(exp_err), 32'(host_err_o));
  endtask

  // Any P+1 consecutive cycles hold one full PWM period.
  task automatic measure_pwm(input string name, input int period, input int duty);
    int high_cnt;
    int other_cnt;
    int expected;
    high_cnt  = 0;
    other_cnt = 0;
    expected  = (duty < period + 1) ? duty : period + 1;
    repeat (2 * (period + 1)) @(negedge clk_sys);
    repeat (period + 1) begin
      @(negedge clk_sys);
      if (pwm_o[0]) begin
        high_cnt++;
      end
      if (|pwm_o[11:1]) begin
        other_cnt++;
      end
    end
    check_value({name, " ch0 high cycles"}, 32'(expected), 32'(high_cnt));
    check_value({name, " other channels high"}, 32'd0, 32'(other_cnt));
  endtask

  task automatic wait_irq(input string name, input logic level, input int max_cycles);
    int n;
    n = 0;
    n_checks++;
    while (timer_irq !== level && n < max_cycles) begin
      @(negedge clk_sys);
      n++;
    end
    if (timer_irq !== level) begin
      n_errors++;
      $display("Timer interrupt did not reach %b within %0d cycles after %s.",
               level, max_cycles, name);
    end
  endtask

  ////////////////////
  // Stimulus.
  ////////////////////

  initial begin
    logic [31:0] t0;
    logic [31:0] t1;
    seed       = 32'h6e75;
    gp_val     = $random(seed);
    gp_i       = gp_val[GpiBits-1:0];
    arst_n     = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_be    = '0;
    host_wdata = '0;
    gpo_model  = '0;

    // GPIO output register with byte enables.
    add_test("gpo write all", 1, GpioAddr, 4'b1111, 32'h00A5_5AC3, 32'h0, 0);
    add_test("gpo read all", 0, GpioAddr, 4'b1111, 32'h0, 32'h00A5_5AC3, 0);
    add_test("gpo write byte1", 1, GpioAddr, 4'b0010, 32'h1122_3344, 32'h0, 0);
    add_test("gpo read byte1", 0, GpioAddr, 4'b1111, 32'h0, 32'h00A5_33C3, 0);
    add_test("gpo write bytes 0 2", 1, GpioAddr, 4'b0101, 32'hFFEE_DDCC, 32'h0, 0);
    add_test("gpo read bytes 0 2", 0, GpioAddr, 4'b1111, 32'h0, 32'h00EE_33CC, 0);
    add_test("gpi read", 0, GpioAddr + 4, 4'b1111, 32'h0, 32'(gp_val[GpiBits-1:0]), 0);
    // Decoder and timer errors.
    add_test("unmapped read", 0, 32'h8000_3000, 4'b1111, 32'h0, 32'h0, 1);
    add_test("unmapped write", 1, 32'h9000_0000, 4'b1111, 32'h1234_5678, 32'h0, 1);
    add_test("timer bad offset", 0, TimerAddr + 32'h10, 4'b1111, 32'h0, 32'h0, 1);
    add_test("mtimecmp lo reset", 0, TimerAddr + 8, 4'b1111, 32'h0, 32'hFFFF_FFFF, 0);
    add_test("mtimecmp hi reset", 0, TimerAddr + 12, 4'b1111, 32'h0, 32'hFFFF_FFFF, 0);
    // PWM channel 0 and channel 1 with zero duty.
    add_test("pwm ch0 write", 1, PwmAddr, 4'b0011, 32'((PwmPeriod << 8) | PwmDuty), 32'h0, 0);
    add_test("pwm ch1 write", 1, PwmAddr + 4, 4'b0011, 32'h0000_0500, 32'h0, 0);
    add_test("pwm ch0 read", 0, PwmAddr, 4'b1111, 32'h0, 32'((PwmPeriod << 8) | PwmDuty), 0);
    add_test("pwm ch1 read", 0, PwmAddr + 4, 4'b1111, 32'h0, 32'h0000_0500, 0);

    timeout_limit = tbl_name.size() * 4 + PwmWindows + 200;

    repeat (4) @(posedge clk_sys);
    #2;
    arst_n = 1'b1;
    @(negedge clk_sys);
    check_value("reset rvalid", 32'd0, 32'(host_rvalid_o));
    check_value("reset err", 32'd0, 32'(host_err_o));
    check_value("reset gp_o", 32'd0, 32'(gp_o));
    check_value("reset pwm_o", 32'd0, 32'(pwm_o));
    check_value("reset irq", 32'd0, 32'(timer_irq));

    for (int i = 0; i < tbl_name.size(); i++) begin
      bus_check(tbl_name[i], tbl_we[i], tbl_addr[i], tbl_be[i], tbl_wdata[i],
                tbl_rdata[i], tbl_err[i]);
      // Mirror GPIO writes; byte 3 is beyond the output width.
      if (tbl_we[i] && tbl_addr[i] == GpioAddr) begin
        for (int b = 0; b < GpoBits / 8; b++) begin
          if (tbl_be[i][b]) begin
            gpo_model[b*8 +: 8] = tbl_wdata[i][b*8 +: 8];
          end
        end
        check_value({tbl_name[i], " gp_o"}, 32'(gpo_model), 32'(gp_o));
      end
    end

    measure_pwm("pwm duty below period", PwmPeriod, PwmDuty);
    bus_check("pwm ch0 rewrite", 1, PwmAddr, 4'b0011, 32'((PwmPeriod << 8) | PwmDutyBig),
              32'h0, 0);
    measure_pwm("pwm duty above period", PwmPeriod, PwmDutyBig);

    // Back-to-back accesses leave one idle cycle between the requests.
    bus_access(0, TimerAddr, 4'b1111, 32'h0);
    t0 = host_rdata_o;
    check_value("mtime first read rvalid", 32'd1, 32'(host_rvalid_o));
    check_value("mtime first read err", 32'd0, 32'(host_err_o));
    repeat (IdleExtra) @(posedge clk_sys);
    bus_access(0, TimerAddr, 4'b1111, 32'h0);
    t1 = host_rdata_o;
    check_value("mtime second read rvalid", 32'd1, 32'(host_rvalid_o));
    check_value("mtime second read err", 32'd0, 32'(host_err_o));
    check_value("mtime delta", 32'(IdleExtra + 1 + 1), t1 - t0);

    // Interrupt on; one of the allowed cycles has passed when the access returns.
    bus_check("mtimecmp hi zero", 1, TimerAddr + 12, 4'b1111, 32'h0, 32'h0, 0);
    check_value("irq before cmp lo", 32'd0, 32'(timer_irq));
    bus_check("mtimecmp lo zero", 1, TimerAddr + 8, 4'b1111, 32'h0, 32'h0, 0);
    wait_irq("mtimecmp zero", 1'b1, IrqCycles - 1);
    bus_check("mtimecmp lo ones", 1, TimerAddr + 8, 4'b1111, 32'hFFFF_FFFF, 32'h0, 0);
    bus_check("mtimecmp hi ones", 1, TimerAddr + 12, 4'b1111, 32'hFFFF_FFFF, 32'h0, 0);
    wait_irq("mtimecmp ones", 1'b0, IrqCycles - 1);

    repeat (2) @(posedge clk_sys);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog.
  always @(posedge clk_sys) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles.", timeout_limit);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
periph_pkg.sv
periph_bus_decode.sv
gpio_regs.sv
pwm_bank.sv
mtimer.sv
sonata_periph_top.sv
tb_sonata_periph.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_sonata_periph \
  --Mdir obj_dir -o sim_tb \
  -f tb.f

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Testbench reported failure."
  exit 1
fi

echo "Testbench run complete."
exit 0
